// File: include/blimp_cfg.svh
// Blimp core configuration
// Reset fetch address, reorder buffer depth and multiplier latency

`ifndef BLIMP_CFG_SVH
`define BLIMP_CFG_SVH

// First fetch address out of reset
`define BLIMP_RST_ADDR 32'h0000_0200

// Reorder buffer entries, power of two so pointers wrap for free
`define BLIMP_ROB_ENTRIES 8

// Multiplier pipeline depth in cycles
// The datapath in mul_unit is built for exactly three stages
`define BLIMP_MUL_STAGES 3

`endif

// File: hw/blimp_pkg.sv
// Blimp shared types
// Memory messages, dispatch and result records, commit trace record

`default_nettype none

`include "blimp_cfg.svh"

package blimp_pkg;

  // ROB index, also the in-flight instruction tag
  typedef logic [$clog2(`BLIMP_ROB_ENTRIES)-1:0] rob_tag_t;

  // Instruction fetch request
  typedef struct packed {
    logic [31:0] addr;
  } mem_req_t;

  // Instruction fetch response
  typedef struct packed {
    logic [31:0] data;
  } mem_resp_t;

  // One operation sent to an execution unit
  typedef struct packed {
    rob_tag_t    tag;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  waddr;
    logic        wen;
  } issue_t;

  // Finished result heading for the ROB
  typedef struct packed {
    rob_tag_t    tag;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } result_t;

  // Retired instruction, doubles as register file write port
  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } commit_t;

endpackage

`default_nettype wire

// File: hw/fetch_unit.sv
// Blimp fetch unit
// Keeps the pc and a single outstanding instruction request, and holds
// the returned word in a one-entry buffer until decode takes it

`default_nettype none

`include "blimp_cfg.svh"

module fetch_unit (
  input  logic                 clk,
  input  logic                 rst,
  output blimp_pkg::mem_req_t  imem_req,
  output logic                 imem_req_val,
  input  logic                 imem_req_rdy,
  input  blimp_pkg::mem_resp_t imem_resp,
  input  logic                 imem_resp_val,
  output logic                 imem_resp_rdy,
  output logic [31:0]          inst,
  output logic [31:0]          inst_pc,
  output logic                 inst_val,
  input  logic                 inst_rdy
);
  import blimp_pkg::*;

  // IDLE only lasts one cycle after reset
  typedef enum logic [1:0] {F_IDLE, F_SEND, F_WAIT, F_HOLD} fetch_state_t;

  fetch_state_t state;
  logic [31:0]  pc;

  assign imem_req.addr = pc;
  assign imem_req_val  = (state == F_SEND);
  assign imem_resp_rdy = (state == F_WAIT);
  assign inst_val      = (state == F_HOLD);

  //----------------------------------------------------------------------
  // Request control
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= F_IDLE;
      pc    <= `BLIMP_RST_ADDR;
    end else begin
      case (state)
        F_IDLE: state <= F_SEND;
        F_SEND: if (imem_req_rdy) state <= F_WAIT;
        F_WAIT: begin
          if (imem_resp_val) begin
            state <= F_HOLD;
            // Next sequential word
            pc    <= pc + 32'd4;
          end
        end
        // Next request only once the buffer drains
        F_HOLD:  if (inst_rdy) state <= F_SEND;
        default: state <= F_IDLE;
      endcase
    end
  end

  // Instruction buffer, tagged with the pc it came from
  always_ff @(posedge clk) begin
    if ((state == F_WAIT) && imem_resp_val) begin
      inst    <= imem_resp.data;
      inst_pc <= pc;
    end
  end

endmodule

`default_nettype wire

// File: hw/decode_issue.sv
// Blimp decode and issue stage
// Decodes ADD, ADDI and MUL, reads the register file, tracks pending
// writers in a scoreboard and dispatches to the ALU or multiplier

`default_nettype none

module decode_issue (
  input  logic                clk,
  input  logic                rst,
  input  logic [31:0]         inst,
  input  logic [31:0]         inst_pc,
  input  logic                inst_val,
  output logic                inst_rdy,
  input  blimp_pkg::rob_tag_t alloc_tag,
  input  logic                alloc_rdy,
  output logic                alloc_en,
  output logic [31:0]         alloc_pc,
  output blimp_pkg::issue_t   alu_issue,
  output logic                alu_val,
  output blimp_pkg::issue_t   mul_issue,
  output logic                mul_val,
  input  blimp_pkg::commit_t  commit,
  input  logic                commit_val
);
  import blimp_pkg::*;

  localparam logic [6:0] OP_REG = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;

  logic        d_val;
  logic [31:0] d_inst;
  logic [31:0] d_pc;
  logic [6:0]  opcode;
  logic [6:0]  funct7;
  logic [2:0]  funct3;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] imm;
  logic        is_add;
  logic        is_addi;
  logic        is_mul;
  logic        use_rs1;
  logic        use_rs2;
  logic        wen;
  logic        stall;
  logic        dispatch;
  issue_t      iss;

  logic [31:0] regs [32];
  logic [31:0] pend;
  rob_tag_t    ptag [32];
  // Commits come in tag order, so this tracks the ROB head
  rob_tag_t    cmt_tag;

  //----------------------------------------------------------------------
  // Decode
  //----------------------------------------------------------------------

  assign opcode = d_inst[6:0];
  assign rd     = d_inst[11:7];
  assign funct3 = d_inst[14:12];
  assign rs1    = d_inst[19:15];
  assign rs2    = d_inst[24:20];
  assign funct7 = d_inst[31:25];
  assign imm    = {{20{d_inst[31]}}, d_inst[31:20]};

  assign is_add  = (opcode == OP_REG) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
  assign is_mul  = (opcode == OP_REG) && (funct3 == 3'b000) && (funct7 == 7'b0000001);
  assign is_addi = (opcode == OP_IMM) && (funct3 == 3'b000);
  assign use_rs1 = is_add | is_addi | is_mul;
  assign use_rs2 = is_add | is_mul;
  // Anything else and x0 targets retire without a write
  assign wen     = use_rs1 && (rd != 5'd0);

  // No bypass, wait for the writer to commit
  assign stall    = (use_rs1 && pend[rs1]) || (use_rs2 && pend[rs2]) || !alloc_rdy;
  assign dispatch = d_val && !stall;
  assign inst_rdy = !d_val || dispatch;

  // Unknown opcodes add zero to zero
  assign iss.tag   = alloc_tag;
  assign iss.op_a  = use_rs1 ? regs[rs1] : 32'd0;
  assign iss.op_b  = is_addi ? imm : (use_rs2 ? regs[rs2] : 32'd0);
  assign iss.waddr = use_rs1 ? rd : 5'd0;
  assign iss.wen   = wen;

  assign alu_issue = iss;
  assign mul_issue = iss;
  assign alu_val   = dispatch && !is_mul;
  assign mul_val   = dispatch && is_mul;
  assign alloc_en  = dispatch;
  assign alloc_pc  = d_pc;

  //----------------------------------------------------------------------
  // Decode buffer, register file and scoreboard
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      d_val <= 1'b0;
    end else if (inst_val && inst_rdy) begin
      d_val <= 1'b1;
    end else if (dispatch) begin
      d_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_val && inst_rdy) begin
      d_inst <= inst;
      d_pc   <= inst_pc;
    end
  end

  // x0 is never written so it reads as zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (commit_val && commit.wen && (commit.waddr != 5'd0)) begin
      regs[commit.waddr] <= commit.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend    <= '0;
      cmt_tag <= '0;
    end else begin
      if (commit_val) begin
        cmt_tag <= cmt_tag + 1'b1;
        // Only the youngest writer clears the bit
        if (commit.wen && (ptag[commit.waddr] == cmt_tag)) pend[commit.waddr] <= 1'b0;
      end
      // New writer wins over a same-cycle clear
      if (dispatch && wen) pend[rd] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (dispatch && wen) ptag[rd] <= alloc_tag;
  end

endmodule

`default_nettype wire

// File: hw/alu_unit.sv
// Blimp ALU
// Single-cycle adder with a registered result for the ROB

`default_nettype none

module alu_unit (
  input  logic               clk,
  input  logic               rst,
  input  blimp_pkg::issue_t  issue,
  input  logic               issue_val,
  output blimp_pkg::result_t result,
  output logic               result_val
);
  import blimp_pkg::*;

  logic [31:0] sum;

  // ADD and ADDI both land here, decode already picked op_b
  assign sum = issue.op_a + issue.op_b;

  always_ff @(posedge clk) begin
    if (rst) begin
      result_val <= 1'b0;
    end else begin
      result_val <= issue_val;
    end
  end

  // Result payload with its routing info
  always_ff @(posedge clk) begin
    if (issue_val) begin
      result.tag   <= issue.tag;
      result.waddr <= issue.waddr;
      result.wdata <= sum;
      result.wen   <= issue.wen;
    end
  end

endmodule

`default_nettype wire

// File: hw/mul_unit.sv
// Blimp multiplier
// Three-stage pipeline producing the low 32 bits of op_a * op_b

`default_nettype none

`include "blimp_cfg.svh"

module mul_unit (
  input  logic               clk,
  input  logic               rst,
  input  blimp_pkg::issue_t  issue,
  input  logic               issue_val,
  output blimp_pkg::result_t result,
  output logic               result_val
);
  import blimp_pkg::*;

  localparam int N = `BLIMP_MUL_STAGES;

  logic [N-1:0] vld;
  rob_tag_t     tag_q   [N];
  logic [4:0]   waddr_q [N];
  logic         wen_q   [N];

  logic [31:0]  a_q;
  logic [31:0]  b_q;
  logic [31:0]  p_lo;
  logic [15:0]  p_hi;
  logic [31:0]  prod;

  // Valid bits, one per stage
  always_ff @(posedge clk) begin
    if (rst) begin
      vld <= '0;
    end else begin
      vld <= {vld[N-2:0], issue_val};
    end
  end

  //----------------------------------------------------------------------
  // Datapath and sideband
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    // Stage 1 operand capture
    a_q  <= issue.op_a;
    b_q  <= issue.op_b;
    // Stage 2 partial products
    // a_hi * b_hi lands above bit 31 and is dropped
    p_lo <= a_q * {16'd0, b_q[15:0]};
    p_hi <= a_q[15:0] * b_q[31:16];
    // Stage 3 final sum
    prod <= p_lo + {p_hi, 16'd0};
  end

  always_ff @(posedge clk) begin
    tag_q[0]   <= issue.tag;
    waddr_q[0] <= issue.waddr;
    wen_q[0]   <= issue.wen;
    for (int i = 1; i < N; i++) begin
      tag_q[i]   <= tag_q[i-1];
      waddr_q[i] <= waddr_q[i-1];
      wen_q[i]   <= wen_q[i-1];
    end
  end

  assign result.tag   = tag_q[N-1];
  assign result.waddr = waddr_q[N-1];
  assign result.wdata = prod;
  assign result.wen   = wen_q[N-1];
  assign result_val   = vld[N-1];

endmodule

`default_nettype wire

// File: hw/reorder_buffer.sv
// Blimp reorder buffer
// Hands out tags in program order, takes results in any order and
// retires the oldest finished entry, one per cycle

`default_nettype none

`include "blimp_cfg.svh"

module reorder_buffer (
  input  logic                clk,
  input  logic                rst,
  input  logic                alloc_en,
  input  logic [31:0]         alloc_pc,
  output blimp_pkg::rob_tag_t alloc_tag,
  output logic                alloc_rdy,
  input  blimp_pkg::result_t  alu_result,
  input  logic                alu_result_val,
  input  blimp_pkg::result_t  mul_result,
  input  logic                mul_result_val,
  output blimp_pkg::commit_t  commit,
  output logic                commit_val
);
  import blimp_pkg::*;

  localparam int ENTRIES = `BLIMP_ROB_ENTRIES;
  localparam int TAG_W   = $clog2(ENTRIES);

  rob_tag_t           head;
  rob_tag_t           tail;
  logic [TAG_W:0]     count;
  logic [ENTRIES-1:0] done;
  // Entry payload has exactly the commit record fields
  commit_t            ent_q [ENTRIES];
  logic               fire_alloc;

  assign alloc_rdy  = (count != ENTRIES[TAG_W:0]);
  assign alloc_tag  = tail;
  assign fire_alloc = alloc_en && alloc_rdy;

  // Head retires as soon as its result is in
  assign commit     = ent_q[head];
  assign commit_val = done[head];

  //----------------------------------------------------------------------
  // Pointers, count and done bits
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end else begin
      if (commit_val) begin
        head       <= head + 1'b1;
        done[head] <= 1'b0;
      end
      if (fire_alloc) begin
        tail       <= tail + 1'b1;
        done[tail] <= 1'b0;
      end
      case ({fire_alloc, commit_val})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Both units may finish together, tags always differ
      if (alu_result_val) done[alu_result.tag] <= 1'b1;
      if (mul_result_val) done[mul_result.tag] <= 1'b1;
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (fire_alloc) ent_q[tail].pc <= alloc_pc;
    if (alu_result_val) begin
      ent_q[alu_result.tag].waddr <= alu_result.waddr;
      ent_q[alu_result.tag].wdata <= alu_result.wdata;
      ent_q[alu_result.tag].wen   <= alu_result.wen;
    end
    if (mul_result_val) begin
      ent_q[mul_result.tag].waddr <= mul_result.waddr;
      ent_q[mul_result.tag].wdata <= mul_result.wdata;
      ent_q[mul_result.tag].wen   <= mul_result.wen;
    end
  end

endmodule

`default_nettype wire

// File: hw/blimp_core.sv
// Blimp core top level
// Fetch, decode-issue, ALU and multiplier side by side, and the ROB
// that merges their results into an in-order commit trace

`default_nettype none

module blimp_core (
  input  logic                 clk,
  input  logic                 rst,
  output blimp_pkg::mem_req_t  imem_req,
  output logic                 imem_req_val,
  input  logic                 imem_req_rdy,
  input  blimp_pkg::mem_resp_t imem_resp,
  input  logic                 imem_resp_val,
  output logic                 imem_resp_rdy,
  output blimp_pkg::commit_t   trace,
  output logic                 trace_val
);
  import blimp_pkg::*;

  logic [31:0] inst;
  logic [31:0] inst_pc;
  logic        inst_val;
  logic        inst_rdy;
  rob_tag_t    alloc_tag;
  logic        alloc_rdy;
  logic        alloc_en;
  logic [31:0] alloc_pc;
  issue_t      alu_issue;
  logic        alu_val;
  issue_t      mul_issue;
  logic        mul_val;
  result_t     alu_result;
  logic        alu_result_val;
  result_t     mul_result;
  logic        mul_result_val;

  fetch_unit i_fetch (
    .clk, .rst, .imem_req, .imem_req_val, .imem_req_rdy,
    .imem_resp, .imem_resp_val, .imem_resp_rdy,
    .inst, .inst_pc, .inst_val, .inst_rdy
  );

  // Trace port doubles as the register file write-back
  decode_issue i_decode (
    .clk, .rst, .inst, .inst_pc, .inst_val, .inst_rdy,
    .alloc_tag, .alloc_rdy, .alloc_en, .alloc_pc,
    .alu_issue, .alu_val, .mul_issue, .mul_val,
    .commit (trace), .commit_val (trace_val)
  );

  alu_unit i_alu (
    .clk, .rst, .issue (alu_issue), .issue_val (alu_val),
    .result (alu_result), .result_val (alu_result_val)
  );

  mul_unit i_mul (
    .clk, .rst, .issue (mul_issue), .issue_val (mul_val),
    .result (mul_result), .result_val (mul_result_val)
  );

  reorder_buffer i_rob (
    .clk, .rst, .alloc_en, .alloc_pc, .alloc_tag, .alloc_rdy,
    .alu_result, .alu_result_val, .mul_result, .mul_result_val,
    .commit (trace), .commit_val (trace_val)
  );

endmodule

`default_nettype wire

// File: tb/inst_mem_model.sv
// Instruction memory model for the blimp testbench
// Word array behind the val/rdy request and response channels, with
// optional random request and response delays

`default_nettype none

module inst_mem_model (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 delay_en,
  input  blimp_pkg::mem_req_t  req,
  input  logic                 req_val,
  output logic                 req_rdy,
  output blimp_pkg::mem_resp_t resp,
  output logic                 resp_val,
  input  logic                 resp_rdy
);
  import blimp_pkg::*;

  // 4 KB of words, byte address bits 11:2 pick the word
  logic [31:0] mem [1024];

  integer      seed;
  logic        rst_q;
  logic        busy;
  logic        req_fire;
  logic        resp_fire;
  logic [31:0] addr_q;
  int          resp_wait;
  int          rdy_wait;

  // 0 to 3 cycles when delays are on
  function automatic int pick_delay();
    if (delay_en) begin
      return $random(seed) & 3;
    end else begin
      return 0;
    end
  endfunction

  initial begin
    seed      = 5;
    req_rdy   = 1'b0;
    resp_val  = 1'b0;
    resp      = '0;
    busy      = 1'b0;
    req_fire  = 1'b0;
    resp_fire = 1'b0;
    addr_q    = '0;
    resp_wait = 0;
    rdy_wait  = 0;
  end

  // Reset as seen by the core on the rising edge
  always @(posedge clk) begin
    rst_q <= rst;
  end

  //--------------------------------------------------------------------
  // Channel control, all outputs change on the falling edge
  //--------------------------------------------------------------------

  always @(negedge clk) begin
    if (rst_q) begin
      req_rdy   = 1'b0;
      resp_val  = 1'b0;
      busy      = 1'b0;
      req_fire  = 1'b0;
      resp_fire = 1'b0;
      rdy_wait  = 0;
    end else begin
      // Handshakes from the last rising edge
      if (resp_fire) begin
        resp_val = 1'b0;
        busy     = 1'b0;
        rdy_wait = pick_delay();
      end
      if (req_fire) begin
        req_rdy   = 1'b0;
        busy      = 1'b1;
        resp_wait = pick_delay();
      end
      // Response after its delay
      if (busy && !resp_val) begin
        if (resp_wait == 0) begin
          resp.data = mem[addr_q[11:2]];
          resp_val  = 1'b1;
        end else begin
          resp_wait--;
        end
      end
      // Ready again once idle and the gap is over
      if (!busy && !req_rdy) begin
        if (rdy_wait == 0) begin
          req_rdy = 1'b1;
        end else begin
          rdy_wait--;
        end
      end
      // Values here hold through the next rising edge
      req_fire  = req_val && req_rdy;
      resp_fire = resp_val && resp_rdy;
      if (req_fire) begin
        addr_q = req.addr;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/blimp_tb.sv
// Blimp core testbench
// Runs the programs from the trace file against the core and checks
// every commit record in order

`default_nettype none

`include "blimp_cfg.svh"

module blimp_tb;
  import blimp_pkg::*;

  localparam int MAX_TESTS = 8;
  localparam int MAX_RECS  = 64;

  logic      clk;
  logic      rst;
  logic      delay_en;
  mem_req_t  imem_req;
  logic      imem_req_val;
  logic      imem_req_rdy;
  mem_resp_t imem_resp;
  logic      imem_resp_val;
  logic      imem_resp_rdy;
  commit_t   trace;
  logic      trace_val;

  // Test table from the trace file
  logic [8*16-1:0] t_name  [MAX_TESTS];
  logic [1:0]      t_modes [MAX_TESTS];
  int              t_first [MAX_TESTS];
  int              t_count [MAX_TESTS];
  int              num_tests;
  // One expected commit record per instruction
  logic [31:0]     r_off   [MAX_RECS];
  logic [31:0]     r_word  [MAX_RECS];
  logic [4:0]      r_waddr [MAX_RECS];
  logic [31:0]     r_wdata [MAX_RECS];
  logic            r_wen   [MAX_RECS];

  int run_errors   = 0;
  int pass_cnt     = 0;
  int fail_cnt     = 0;
  int limit_cycles = 0;

  blimp_core i_blimp_core (
    .clk, .rst, .imem_req, .imem_req_val, .imem_req_rdy,
    .imem_resp, .imem_resp_val, .imem_resp_rdy, .trace, .trace_val
  );

  inst_mem_model i_mem (
    .clk, .rst, .delay_en, .req (imem_req), .req_val (imem_req_val),
    .req_rdy (imem_req_rdy), .resp (imem_resp), .resp_val (imem_resp_val),
    .resp_rdy (imem_resp_rdy)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------

  task automatic load_trace(output bit ok);
    int              fd;
    int              n;
    int              nt;
    int              nr;
    bit              eof;
    logic [8*16-1:0] kw;
    logic [8*80-1:0] rest;
    ok  = 1'b1;
    nt  = 0;
    nr  = 0;
    eof = 1'b0;
    fd  = $fopen("tb/blimp_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tb/blimp_trace.txt");
      ok = 1'b0;
    end else begin
      while (!eof && ok) begin
        n = $fscanf(fd, "%s", kw);
        if (n != 1) begin
          eof = 1'b1;
        end else if (kw == "#") begin
          n = $fgets(rest, fd);
        end else if (kw == "test" && nt < MAX_TESTS) begin
          n = $fscanf(fd, "%s %d", t_name[nt], t_modes[nt]);
          t_first[nt] = nr;
          t_count[nt] = 0;
          nt++;
        end else if (kw == "r" && nt > 0 && nr < MAX_RECS) begin
          n = $fscanf(fd, "%h %h %d %h %d", r_off[nr], r_word[nr], r_waddr[nr],
                      r_wdata[nr], r_wen[nr]);
          ok = (n == 5);
          t_count[nt-1]++;
          nr++;
        end else begin
          ok = 1'b0;
        end
      end
      if (!ok) $display("Trace file has a malformed line near record %0d", nr);
      $fclose(fd);
    end
    num_tests = nt;
  endtask

  // Upper bits follow the full address and the opcode decodes as a no-write op
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:7] ^ addr[24:0], 7'h7f};
  endfunction

  task automatic load_memory(input int t);
    logic [31:0] addr;
    for (int i = 0; i < 1024; i++) begin
      addr = {20'd0, i[9:0], 2'b00};
      i_mem.mem[i] = fill_word(addr);
    end
    for (int i = t_first[t]; i < t_first[t] + t_count[t]; i++) begin
      addr = `BLIMP_RST_ADDR + r_off[i];
      i_mem.mem[addr[11:2]] = r_word[i];
    end
  endtask

  task automatic check_word(input string sig, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR time=%0t %s expected %h actual %h", $time, sig, exp, act);
      run_errors++;
    end
  endtask

  // Address and data only matter for a real write
  task automatic check_commit(input int idx);
    check_word("trace.pc", `BLIMP_RST_ADDR + r_off[idx], trace.pc);
    check_word("trace.wen", {31'd0, r_wen[idx]}, {31'd0, trace.wen});
    if (r_wen[idx]) begin
      check_word("trace.waddr", {27'd0, r_waddr[idx]}, {27'd0, trace.waddr});
      check_word("trace.wdata", r_wdata[idx], trace.wdata);
    end
  endtask

  task automatic run_one(input int t, input bit rnd);
    int got;
    int err0;
    bit seen_req;
    err0 = run_errors;
    @(negedge clk);
    rst = 1'b1;
    @(negedge clk);
    delay_en = rnd;
    load_memory(t);
    repeat (15) @(negedge clk);
    rst = 1'b0;
    // Still reset values at release
    check_word("trace_val", 32'd0, {31'd0, trace_val});
    check_word("imem_req_val", 32'd0, {31'd0, imem_req_val});
    seen_req = 1'b0;
    while (!seen_req) begin
      @(negedge clk);
      seen_req = imem_req_val;
    end
    check_word("imem_req.addr", `BLIMP_RST_ADDR, imem_req.addr);
    // Commits in program order
    got = 0;
    while (got < t_count[t]) begin
      @(negedge clk);
      if (trace_val) begin
        check_commit(t_first[t] + got);
        got++;
      end
    end
    if (run_errors == err0) begin
      pass_cnt++;
      $display("%0s %0s: ok, %0d commits", t_name[t], rnd ? "random" : "fixed", got);
    end else begin
      fail_cnt++;
      $display("%0s %0s: FAIL, %0d errors", t_name[t], rnd ? "random" : "fixed",
               run_errors - err0);
    end
  endtask

  // A response only comes back while the fetch buffer is free
  always @(posedge clk) begin
    if (!rst && imem_resp_val) begin
      check_word("imem_resp_rdy", 32'd1, {31'd0, imem_resp_rdy});
    end
  end

  //--------------------------------------------------------------------
  // Main sequence and watchdog
  //--------------------------------------------------------------------

  initial begin : main_seq
    bit ok;
    int total;
    rst      = 1'b1;
    delay_en = 1'b0;
    load_trace(ok);
    if (!ok) begin
      $display("Trace file could not be read, no tests were run");
      $display("Result: FAILED");
      $finish;
    end else begin
      // 200 cycles per record plus reset time per run
      total = 0;
      for (int t = 0; t < num_tests; t++) begin
        total += (t_modes[t][0] + t_modes[t][1]) * (200 * t_count[t] + 20);
      end
      limit_cycles = total;
      for (int t = 0; t < num_tests; t++) begin
        if (t_modes[t][0]) run_one(t, 1'b0);
        if (t_modes[t][1]) run_one(t, 1'b1);
      end
      $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && pass_cnt > 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
      $finish;
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Watchdog ran out after %0d cycles, the commit trace stalled", limit_cycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/blimp_trace.txt
# test <name> <modes>   modes: bit0 fixed memory timing, bit1 random delays
# r <pc offset hex> <instruction hex> <waddr dec> <wdata hex> <wen>
test chain 3
r 00 00500093 1 00000005 1
r 04 ffd08113 2 00000002 1
r 08 002081b3 3 00000007 1
r 0c 80018213 4 fffff807 1
r 10 004202b3 5 fffff00e 1
r 14 7ff28313 6 fffff80d 1
test mul_order 3
r 00 3e800093 1 000003e8 1
r 04 ff900113 2 fffffff9 1
r 08 00c00193 3 0000000c 1
r 0c 02208233 4 ffffe4a8 1
r 10 003182b3 5 00000018 1
r 14 024203b3 7 02ebae40 1
r 18 02720433 8 239b5a00 1
r 1c 001184b3 9 000003f4 1
test x0_write 1
r 00 04d00013 0 00000000 0
r 04 00900093 1 00000009 1
r 08 00108033 0 00000000 0
r 0c 00100133 2 00000009 1
r 10 021001b3 3 00000000 1
r 14 00000000 0 00000000 0
test mul_burst 3
r 00 00300093 1 00000003 1
r 04 ffb00113 2 fffffffb 1
r 08 022081b3 3 fffffff1 1
r 0c 02210233 4 00000019 1
r 10 021082b3 5 00000009 1
r 14 02208333 6 fffffff1 1
r 18 022103b3 7 00000019 1
r 1c 02108433 8 00000009 1
r 20 022084b3 9 fffffff1 1
r 24 02210533 10 00000019 1
r 28 021085b3 11 00000009 1
r 2c 02208633 12 fffffff1 1

// File: sim.f
+incdir+include
hw/blimp_pkg.sv
hw/fetch_unit.sv
hw/decode_issue.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/reorder_buffer.sv
hw/blimp_core.sv
tb/inst_mem_model.sv
tb/blimp_tb.sv
